// ==== dv/div_tb.sv ====
module div_tb;

    localparam int lat = div_pkg::div_w + 4;  // Unloaded op_valid to res_valid
    localparam int tmo = 40 * lat;            // Cycle limit of one wait

    logic              clk;
    logic              rst_n;
    logic              op_valid = 1'b0;
    div_pkg::div_op_t  op = '0;
    logic              in_credit;
    logic              res_valid;
    div_pkg::div_res_t res;
    logic              out_credit = 1'b0;

    div_pkg::div_res_t exp_mem [64];        // Expected results in send order
    div_pkg::div_res_t exp_head;            // Oldest outstanding result
    logic [5:0]        sb_wr = '0;
    logic [5:0]        sb_rd = '0;
    logic [31:0]       lfsr = 32'hfadf_e437;     // Operand stream
    logic [31:0]       dn_lfsr = 32'hfadf_e437;  // Downstream hold-off stream
    int                sent_cnt = 0;   // op_valid cycles
    int                cred_cnt = 0;   // in_credit pulses
    int                rcv_cnt = 0;    // Results taken downstream
    int                ret_cnt = 0;    // out_credit pulses returned
    int                holdoff = 0;
    int                since_op = 0;   // Cycles since the last op_valid
    int                held_res = 0;   // Results while credits are withheld
    int                held_cred = 0;  // in_credit pulses while credits are withheld
    int                avail;          // Upstream credits in hand
    logic              hold = 1'b0;    // Downstream withholds credits
    logic              lat_mode = 1'b0;
    logic              chk_hold = 1'b0;
    logic              chk_totals = 1'b0;
    logic              aborted = 1'b0;
    int                err_cnt = 0;
    int                err_base = 0;
    int                pass_tests = 0;
    int                fail_tests = 0;

    div_tb_clk u_clk (.clk(clk), .rst_n(rst_n));

    div_unit DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .op         (op),
        .in_credit  (in_credit),
        .res_valid  (res_valid),
        .res        (res),
        .out_credit (out_credit)
    );

    assign exp_head = exp_mem[sb_rd];
    assign avail    = div_pkg::queue_depth - sent_cnt + cred_cnt;

    // Upstream credit model and result bookkeeping
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sent_cnt  <= 0;
            cred_cnt  <= 0;
            rcv_cnt   <= 0;
            since_op  <= 0;
            held_res  <= 0;
            held_cred <= 0;
        end else begin
            if (op_valid) sent_cnt <= sent_cnt + 1;
            if (in_credit) cred_cnt <= cred_cnt + 1;
            if (res_valid) begin
                rcv_cnt <= rcv_cnt + 1;
                sb_rd   <= sb_rd + 1'b1;  // Scoreboard pop
            end
            since_op <= op_valid ? 1 : since_op + 1;
            if (hold) begin
                if (res_valid) held_res <= held_res + 1;
                if (in_credit) held_cred <= held_cred + 1;
            end else begin
                held_res  <= 0;
                held_cred <= 0;
            end
        end
    end

    // Downstream returns one credit per result after a random hold-off
    always @(negedge clk) begin
        out_credit <= 1'b0;
        if (rst_n && !hold && rcv_cnt != ret_cnt) begin
            if (holdoff == 0) begin
                out_credit <= 1'b1;
                ret_cnt    <= ret_cnt + 1;
                holdoff    <= take_bits(dn_lfsr, 2);  // 0 to 3 cycles
            end else begin
                holdoff <= holdoff - 1;
            end
        end
    end

    a_quiet : assert property (@(posedge clk) disable iff (!rst_n)
        (sent_cnt == 0) |-> (!in_credit && !res_valid))
        else log_error("in_credit or res_valid rose before any operand");
    a_quot : assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (res.quotient == exp_head.quotient))
        else begin
            $display("ERR res.quotient expected %h actual %h",
                     $sampled(exp_head.quotient), $sampled(res.quotient));
            err_cnt++;
        end
    a_rem : assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (res.remainder == exp_head.remainder))
        else begin
            $display("ERR res.remainder expected %h actual %h",
                     $sampled(exp_head.remainder), $sampled(res.remainder));
            err_cnt++;
        end
    a_extra : assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (sb_rd != sb_wr))
        else log_error("a result arrived with no operand outstanding");
    a_latency : assert property (@(posedge clk) disable iff (!rst_n)
        (lat_mode && res_valid) |-> (since_op == lat))
        else begin
            $display("ERR res_valid latency expected %h actual %h", lat, $sampled(since_op));
            err_cnt++;
        end
    a_held_res : assert property (@(posedge clk) disable iff (!rst_n)
        (hold && res_valid) |-> (held_res < div_pkg::out_credits))
        else log_error("more results sent than downstream credits allow");
    // Withheld credits allow out_credits sent plus one held and one in flight
    a_held_cred : assert property (@(posedge clk) disable iff (!rst_n)
        (hold && in_credit) |-> (held_cred < div_pkg::out_credits + 2))
        else log_error("in_credit kept coming after the queue should be full");
    a_hold_full : assert property (@(posedge clk) disable iff (!rst_n)
        chk_hold |-> (avail == 0))
        else log_error("upstream still had credits, the queue never filled");
    a_spend : assert property (@(posedge clk) disable iff (!rst_n)
        op_valid |-> (avail > 0))
        else log_error("upstream sent without a credit");
    a_refund : assert property (@(posedge clk) disable iff (!rst_n)
        in_credit |-> (avail < div_pkg::queue_depth))
        else log_error("in_credit returned a credit that was never spent");
    a_totals : assert property (@(posedge clk) disable iff (!rst_n)
        chk_totals |-> (cred_cnt == sent_cnt))
        else begin
            $display("ERR in_credit count expected %h actual %h",
                     $sampled(sent_cnt), $sampled(cred_cnt));
            err_cnt++;
        end

    // Galois LFSR stepped once per bit taken, state LSB first
    function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v  = {v[30:0], st[0]};
            st = (st >> 1) ^ (st[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic div_pkg::div_op_t rand_pair(input logic zero_div);
        div_pkg::div_op_t p;
        logic [31:0]      v;
        logic [3:0]       sh;
        v          = take_bits(lfsr, div_pkg::div_w);
        p.dividend = v[div_pkg::div_w-1:0];
        v          = take_bits(lfsr, div_pkg::div_w);
        sh         = 4'(take_bits(lfsr, 4));
        p.divisor  = v[div_pkg::div_w-1:0] >> sh;  // Spread of divisor sizes
        if (zero_div) begin
            p.divisor = '0;
        end else if (p.divisor == '0) begin
            p.divisor = 1;
        end
        return p;
    endfunction

    // Unsigned divide where a zero divisor gives all ones and the dividend back
    function automatic div_pkg::div_res_t ref_div(input div_pkg::div_op_t p);
        div_pkg::div_res_t r;
        if (p.divisor == '0) begin
            r.quotient  = '1;
            r.remainder = p.dividend;
        end else begin
            r.quotient  = p.dividend / p.divisor;
            r.remainder = p.dividend % p.divisor;
        end
        return r;
    endfunction

    task automatic log_error(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        err_cnt++;
        aborted = 1'b1;
    endtask

    // Starts and ends on a falling edge
    task automatic send_op(input div_pkg::div_op_t p);
        int n;
        n = 0;
        while (avail <= 0 && !aborted) begin
            @(negedge clk);
            n++;
            if (n > tmo) fail_timeout("an upstream credit");
        end
        if (!aborted) begin
            op_valid       = 1'b1;
            op             = p;
            exp_mem[sb_wr] = ref_div(p);  // Scoreboard push
            sb_wr          = sb_wr + 1'b1;
            @(negedge clk);
            op_valid       = 1'b0;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (sb_rd != sb_wr && !aborted) begin
            @(negedge clk);
            n++;
            if (n > tmo) fail_timeout("all outstanding results");
        end
    endtask

    task automatic wait_credits_home();
        int n;
        n = 0;
        while (rcv_cnt != ret_cnt && !aborted) begin
            @(negedge clk);
            n++;
            if (n > tmo) fail_timeout("downstream credits to return");
        end
    endtask

    task automatic end_test(input string name);
        repeat (2) @(negedge clk);  // Let the last assertions settle
        if (err_cnt == err_base) begin
            pass_tests++;
            $display("%s: pass", name);
        end else begin
            fail_tests++;
            $display("%s: fail, %0d errors", name, err_cnt - err_base);
        end
        err_base = err_cnt;
    endtask

    initial begin
        div_pkg::div_op_t p;
        int               n;
        int               c;
        n = 0;
        while (rst_n !== 1'b1 && !aborted) begin  // Reset release lands on a falling edge
            @(posedge clk);
            n++;
            if (n > 20) fail_timeout("reset release");
        end
        @(negedge clk);

        repeat (10) @(negedge clk);  // Outputs stay low while nothing is sent
        end_test("test 1 reset quiet");

        repeat (12) send_op(rand_pair(1'b0));
        wait_drained();
        end_test("test 2 random divide");

        p = '0;
        send_op(p);
        p.dividend = '1;
        send_op(p);
        repeat (3) send_op(rand_pair(1'b1));
        wait_drained();
        end_test("test 3 zero divisor");

        lat_mode = 1'b1;
        repeat (4) begin
            wait_credits_home();
            send_op(rand_pair(1'b0));
            wait_drained();
        end
        lat_mode = 1'b0;
        end_test("test 4 unloaded latency");

        wait_credits_home();
        hold = 1'b1;
        n    = 0;
        for (c = 0; c < 6 * lat && !aborted; c++) begin  // Fill everything up
            if (avail > 0 && n < 8) begin
                send_op(rand_pair(1'b0));
                n++;
            end else begin
                @(negedge clk);
            end
        end
        chk_hold = 1'b1;
        @(negedge clk);
        chk_hold = 1'b0;
        hold     = 1'b0;  // Credits flow again
        while (n < 8 && !aborted) begin
            send_op(rand_pair(1'b0));
            n++;
        end
        wait_drained();
        end_test("test 5 back-pressure");

        wait_credits_home();
        chk_totals = 1'b1;
        @(negedge clk);
        chk_totals = 1'b0;
        end_test("test 6 credit totals");

        $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_cnt);
        if (err_cnt == 0 && fail_tests == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/div_tb_clk.sv ====
// Free running clock, period 8, and power-on reset
module div_tb_clk (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held over 5 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== flist.f ====
hw/div_pkg.sv
hw/div_alu.sv
hw/div_datapath.sv
hw/div_ctrl.sv
hw/div_op_queue.sv
hw/div_result_port.sv
hw/div_unit.sv
dv/div_tb_clk.sv
dv/div_tb.sv

// ==== hw/div_alu.sv ====
// Single restoring step of the divider
// Trial subtraction of the divisor from the shifted partial remainder
// Borrow out means the divisor did not fit, so the old value is kept
module div_alu (
    input  logic [div_pkg::div_w:0]   part_rem,  // Shifted remainder with next dividend bit
    input  logic [div_pkg::div_w-1:0] divisor,
    output logic [div_pkg::div_w:0]   next_rem,  // Restored or reduced remainder
    output logic                      q_bit      // Quotient bit for this step
);

    // One bit wider than part_rem so the borrow lands in the MSB
    logic [div_pkg::div_w+1:0] diff;
    logic                      sign;  // Set when the trial went negative

    // Trial subtraction, both sides zero extended
    assign diff = {1'b0, part_rem} - {2'b00, divisor};

    assign sign = diff[div_pkg::div_w+1];  // Borrow out of the subtraction

    // Divisor fits when no borrow
    assign q_bit = ~sign;

    // Restore on borrow, otherwise take the reduced value
    // A zero divisor never borrows, so the dividend bits just shift through
    always_comb begin
        if (sign) begin
            next_rem = part_rem;  // Restore
        end else begin
            next_rem = diff[div_pkg::div_w:0];  // Keep the difference
        end
    end

endmodule

// ==== hw/div_ctrl.sv ====
// Divider sequencing FSM
// idle pops and loads, run steps, finish and wait hand the result to the port
module div_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic q_nonempty,  // Operand queue has a pair
    input  logic port_busy,   // Result port still holds a result
    input  logic iter_done,   // Last step in progress
    output logic q_pop,
    output logic load,
    output logic step,
    output logic capture,
    output logic res_push
);

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_RUN    = 2'd1,
        ST_FINISH = 2'd2,
        ST_WAIT   = 2'd3
    } state_t;

    state_t state;
    state_t state_nxt;

    // State register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Next state and outputs
    always_comb begin
        state_nxt = state;
        q_pop     = 1'b0;
        load      = 1'b0;
        step      = 1'b0;
        capture   = 1'b0;
        res_push  = 1'b0;
        case (state)
            ST_IDLE: begin
                if (q_nonempty) begin
                    q_pop     = 1'b1;  // Pop and load in the same cycle
                    load      = 1'b1;
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN: begin
                step = 1'b1;  // One quotient bit per cycle
                if (iter_done) begin
                    state_nxt = ST_FINISH;
                end
            end
            ST_FINISH: begin
                if (!port_busy) begin
                    capture   = 1'b1;
                    res_push  = 1'b1;
                    state_nxt = ST_IDLE;
                end else begin
                    state_nxt = ST_WAIT;  // Port full, hold the result here
                end
            end
            ST_WAIT: begin
                if (!port_busy) begin  // Credit came back downstream
                    capture   = 1'b1;
                    res_push  = 1'b1;
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // A load mid-division would corrupt the working registers
    a_no_step_load : assert property (@(posedge clk) disable iff (!rst_n)
        !(step && load))
        else $error("step and load high together");

endmodule

// ==== hw/div_datapath.sv ====
// Shift, subtract and restore datapath
// Dividend register doubles as the quotient register, bits shift in from the right
module div_datapath (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load,       // Take a new operand pair
    input  logic              step,       // One restoring iteration
    input  logic              capture,    // Present the finished pair on res_word
    input  div_pkg::div_op_t  op_in,      // Head of the operand queue
    output logic              iter_done,  // Last step is in progress
    output div_pkg::div_res_t res_word    // Quotient and remainder
);

    logic [div_pkg::div_w-1:0] dvsr;     // Divisor register
    logic [div_pkg::div_w-1:0] quo;      // Dividend going in, quotient coming out
    logic [div_pkg::div_w-1:0] rem;      // Partial remainder
    logic [div_pkg::cnt_w-1:0] cnt;      // Index of the step in progress, 1 based
    logic [div_pkg::div_w:0]   part_rem; // Remainder shifted left with next dividend bit
    logic [div_pkg::div_w:0]   next_rem; // ALU choice
    logic                      q_bit;    // New quotient bit

    // Left shift of the remainder/quotient pair by one
    assign part_rem = {rem, quo[div_pkg::div_w-1]};

    div_alu u_alu (
        .part_rem (part_rem),
        .divisor  (dvsr),
        .next_rem (next_rem),
        .q_bit    (q_bit)
    );

    // Operand and working registers, payload only
    always_ff @(posedge clk) begin
        if (load) begin
            dvsr <= op_in.divisor;
            quo  <= op_in.dividend;
            rem  <= '0;  // Partial remainder starts empty
        end else if (step) begin
            rem <= next_rem[div_pkg::div_w-1:0];          // Top bit is always clear
            quo <= {quo[div_pkg::div_w-2:0], q_bit};      // Quotient bit in from the right
        end
    end

    // Iteration counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= {{(div_pkg::cnt_w-1){1'b0}}, 1'b1};  // First step is step 1
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

    // High during step div_w, the controller leaves the run state on it
    assign iter_done = (cnt == div_pkg::div_w[div_pkg::cnt_w-1:0]);

    // Finished pair shows up only in the capture cycle
    always_comb begin
        if (capture) begin
            res_word.quotient  = quo;
            res_word.remainder = rem;
        end else begin
            res_word = '0;
        end
    end

    // Remainder must stay below the divisor, or pass the dividend through on zero
    a_rem_fits : assert property (@(posedge clk) disable iff (!rst_n)
        step |-> !next_rem[div_pkg::div_w])
        else $error("ALU remainder overflowed the remainder register");

endmodule

// ==== hw/div_op_queue.sv ====
// Operand queue with upstream credit return
// Incoming pairs go through a staging register, then into a small circular buffer
module div_op_queue (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             op_valid,    // Upstream spends a credit
    input  div_pkg::div_op_t op,
    input  logic             q_pop,       // Controller takes the head
    output logic             q_nonempty,
    output div_pkg::div_op_t q_op,        // Head entry
    output logic             in_credit    // One credit back per pop
);

    div_pkg::div_op_t            mem [div_pkg::queue_depth];
    div_pkg::div_op_t            wr_op;  // Staged pair
    logic                        wr_v;   // Staged pair valid
    logic [div_pkg::qptr_w-1:0]  wptr;
    logic [div_pkg::qptr_w-1:0]  rptr;
    logic [div_pkg::qcnt_w-1:0]  fill;   // Entries in the buffer

    // Staging register, this is the queue write cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_v <= 1'b0;
        end else begin
            wr_v <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        wr_op <= op;  // Payload, qualified by wr_v
        if (wr_v) begin
            mem[wptr] <= wr_op;
        end
    end

    // Pointers wrap at queue_depth, fill moves up, down or stays
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr      <= '0;
            rptr      <= '0;
            fill      <= '0;
            in_credit <= 1'b0;
        end else begin
            if (wr_v) begin
                wptr <= (wptr == div_pkg::queue_depth - 1) ? '0 : wptr + 1'b1;
            end
            if (q_pop) begin
                rptr <= (rptr == div_pkg::queue_depth - 1) ? '0 : rptr + 1'b1;
            end
            if (wr_v && !q_pop) begin
                fill <= fill + 1'b1;
            end else if (q_pop && !wr_v) begin
                fill <= fill - 1'b1;
            end
            in_credit <= q_pop;  // Registered pop is the credit pulse
        end
    end

    assign q_nonempty = (fill != '0);
    assign q_op       = mem[rptr];

    // A write into a full buffer means upstream sent without a credit
    a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
        wr_v |-> (fill < div_pkg::queue_depth))
        else $error("operand queue written while full, upstream ignored credits");

    a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
        q_pop |-> q_nonempty)
        else $error("operand queue popped while empty");

endmodule

// ==== hw/div_pkg.sv ====
package div_pkg;

    // Operand width, any even width up to 31 works
    localparam int div_w = 16;
    // Iteration counter width, must hold div_w
    localparam int cnt_w = 5;

    // Operand queue entries, also the upstream agent's starting credits
    localparam int queue_depth = 2;
    localparam int qptr_w      = $clog2(queue_depth);      // Queue read/write pointer
    localparam int qcnt_w      = $clog2(queue_depth + 1);  // Queue fill count

    // Downstream credits held by the result port after reset
    localparam int out_credits = 2;
    localparam int cred_w      = $clog2(out_credits + 1);  // Credit counter width

    // Operand pair as it arrives from upstream
    typedef struct packed {
        logic [div_w-1:0] dividend;  // Upper half
        logic [div_w-1:0] divisor;   // Lower half
    } div_op_t;

    // Result pair as it leaves downstream
    typedef struct packed {
        logic [div_w-1:0] quotient;   // Upper half
        logic [div_w-1:0] remainder;  // Lower half
    } div_res_t;

endpackage

// ==== hw/div_result_port.sv ====
// One entry result holder with downstream credits
// Sends as soon as it holds a result and at least one credit
module div_result_port (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              res_push,    // Controller hands over a result
    input  div_pkg::div_res_t res_word,
    input  logic              out_credit,  // Downstream returns one credit
    output logic              port_busy,   // Result held, not yet sent
    output logic              res_valid,
    output div_pkg::div_res_t res
);

    div_pkg::div_res_t          held;     // Stored result
    logic                       full;
    logic [div_pkg::cred_w-1:0] credits;  // Downstream credits in hand

    // Send when a result and a credit are both present
    assign res_valid = full && (credits != '0);
    assign port_busy = full;
    assign res       = held;

    always_ff @(posedge clk) begin
        if (res_push) begin
            held <= res_word;  // Payload
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (res_push) begin
            full <= 1'b1;
        end else if (res_valid) begin
            full <= 1'b0;  // Sent, slot free next cycle
        end
    end

    // Credit counter, one return and one send cancel out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= div_pkg::out_credits[div_pkg::cred_w-1:0];
        end else begin
            case ({out_credit, res_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Downstream returned more credits than it was given
    a_credit_max : assert property (@(posedge clk) disable iff (!rst_n)
        credits <= div_pkg::out_credits)
        else $error("downstream credit count above out_credits");

    a_no_push_busy : assert property (@(posedge clk) disable iff (!rst_n)
        res_push |-> !full)
        else $error("result pushed while port busy");

endmodule

// ==== hw/div_unit.sv ====
// Credit based iterative divider, top level
module div_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              op_valid,
    input  div_pkg::div_op_t  op,
    output logic              in_credit,
    output logic              res_valid,
    output div_pkg::div_res_t res,
    input  logic              out_credit
);

    logic              q_nonempty;
    logic              q_pop;
    div_pkg::div_op_t  q_op;       // Queue head into the datapath
    logic              load;
    logic              step;
    logic              capture;
    logic              iter_done;
    logic              port_busy;
    logic              res_push;
    div_pkg::div_res_t res_word;   // Datapath result into the port

    div_op_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .op         (op),
        .q_pop      (q_pop),
        .q_nonempty (q_nonempty),
        .q_op       (q_op),
        .in_credit  (in_credit)
    );

    div_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .q_nonempty (q_nonempty),
        .port_busy  (port_busy),
        .iter_done  (iter_done),
        .q_pop      (q_pop),
        .load       (load),
        .step       (step),
        .capture    (capture),
        .res_push   (res_push)
    );

    div_datapath u_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .step      (step),
        .capture   (capture),
        .op_in     (q_op),
        .iter_done (iter_done),
        .res_word  (res_word)
    );

    div_result_port u_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .res_push   (res_push),
        .res_word   (res_word),
        .out_credit (out_credit),
        .port_busy  (port_busy),
        .res_valid  (res_valid),
        .res        (res)
    );

endmodule
